// ==== hw/ifetch_pkg.sv ====
// ==================================================
// Shared widths, buffer sizing and controller state
// for the instruction fetch stage. Import where needed
// ==================================================
package ifetch_pkg;

  // Bus and instruction word widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Fetch granularity is one 32-bit word
  localparam int unsigned WORD_BYTES = 4;
  localparam int unsigned ADDR_LSB   = 2;

  // Prefetch depth and credit pool size
  // Any power of two from 2 to 16
  localparam int unsigned BUF_DEPTH_DEFAULT = 4;

  // Request controller state
  //   REQ_IDLE   fetch disabled, no bus requests
  //   REQ_ACTIVE requests issued while credits remain
  typedef enum logic {
    REQ_IDLE   = 1'b0,
    REQ_ACTIVE = 1'b1
  } req_state_e;

endpackage

// ==== hw/ifetch_req_ctrl.sv ====
// ==================================================
// Fetch request controller. Issues word requests under
// credit control and discards stale responses on branch
// ==================================================
`timescale 1ns/1ps

module ifetch_req_ctrl #(
  parameter int unsigned BufDepth = ifetch_pkg::BUF_DEPTH_DEFAULT
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          fetch_enable_i,
  input  logic                          branch_i,
  input  logic [ifetch_pkg::ADDR_W-1:0] branch_addr_i,
  // Instruction bus
  output logic                          instr_req_o,
  input  logic                          instr_gnt_i,
  output logic [ifetch_pkg::ADDR_W-1:0] instr_addr_o,
  input  logic                          instr_rvalid_i,
  input  logic [ifetch_pkg::DATA_W-1:0] instr_rdata_i,
  input  logic                          instr_err_i,
  // Buffer side
  input  logic                          credit_ret_i,
  output logic                          push_valid_o,
  output logic [ifetch_pkg::DATA_W-1:0] push_rdata_o,
  output logic [ifetch_pkg::ADDR_W-1:0] push_addr_o,
  output logic                          push_err_o
);
  import ifetch_pkg::*;

  localparam int unsigned CntW = $clog2(BufDepth + 1);
  localparam int unsigned PtrW = $clog2(BufDepth);

  req_state_e        state_q, state_d;
  logic [ADDR_W-1:0] addr_q, addr_d;
  logic [CntW-1:0]   credits_q, credits_d;
  logic [CntW-1:0]   outstanding_q, outstanding_d;
  logic [CntW-1:0]   drop_q, drop_d;
  logic [ADDR_W-1:0] rsp_addr_mem [BufDepth];
  logic [PtrW-1:0]   rsp_wr_ptr_q, rsp_rd_ptr_q;
  logic              req_fire;
  logic              rsp_drop;

  // No request in the branch cycle
  assign instr_req_o  = (state_q == REQ_ACTIVE) && (credits_q != '0) && !branch_i;
  assign instr_addr_o = addr_q;
  assign req_fire     = instr_req_o && instr_gnt_i;

  // Old-stream responses include one landing with the branch itself
  assign rsp_drop = instr_rvalid_i && ((drop_q != '0) || branch_i);

  assign push_valid_o = instr_rvalid_i && !rsp_drop;
  assign push_rdata_o = instr_rdata_i;
  assign push_addr_o  = rsp_addr_mem[rsp_rd_ptr_q];
  assign push_err_o   = instr_err_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      REQ_IDLE: begin
        if (fetch_enable_i) begin
          state_d = REQ_ACTIVE;
        end
      end
      REQ_ACTIVE: begin
        // A waiting request is held until granted
        if (!fetch_enable_i && (!instr_req_o || instr_gnt_i)) begin
          state_d = REQ_IDLE;
        end
      end
      default: begin
        state_d = REQ_IDLE;
      end
    endcase
  end

  always_comb begin
    outstanding_d = outstanding_q + CntW'(req_fire) - CntW'(instr_rvalid_i);

    if (branch_i) begin
      addr_d    = {branch_addr_i[ADDR_W-1:ADDR_LSB], {ADDR_LSB{1'b0}}};
      // Everything still in flight after this cycle is stale
      drop_d    = outstanding_q - CntW'(instr_rvalid_i);
      credits_d = CntW'(BufDepth) - drop_d;
    end else begin
      addr_d    = req_fire ? addr_q + ADDR_W'(WORD_BYTES) : addr_q;
      drop_d    = rsp_drop ? drop_q - 1'b1 : drop_q;
      credits_d = credits_q - CntW'(req_fire) + CntW'(credit_ret_i) + CntW'(rsp_drop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q       <= REQ_IDLE;
      addr_q        <= '0;
      credits_q     <= CntW'(BufDepth);
      outstanding_q <= '0;
      drop_q        <= '0;
      rsp_wr_ptr_q  <= '0;
      rsp_rd_ptr_q  <= '0;
    end else begin
      state_q       <= state_d;
      addr_q        <= addr_d;
      credits_q     <= credits_d;
      outstanding_q <= outstanding_d;
      drop_q        <= drop_d;
      if (req_fire) begin
        rsp_wr_ptr_q <= rsp_wr_ptr_q + 1'b1;
      end
      if (instr_rvalid_i) begin
        rsp_rd_ptr_q <= rsp_rd_ptr_q + 1'b1;
      end
    end
  end

  // Addresses of granted requests, in bus order
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_addr_mem[rsp_wr_ptr_q] <= addr_q;
    end
  end

endmodule

// ==== hw/ifetch_prefetch_buf.sv ====
// ==================================================
// Prefetch buffer. Holds fetched words with address and
// error, hands them out over valid/ready, returns credits
// ==================================================
`timescale 1ns/1ps

module ifetch_prefetch_buf #(
  parameter int unsigned BufDepth = ifetch_pkg::BUF_DEPTH_DEFAULT
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          branch_i,
  // Fill side always has room thanks to credits
  input  logic                          push_valid_i,
  input  logic [ifetch_pkg::DATA_W-1:0] push_rdata_i,
  input  logic [ifetch_pkg::ADDR_W-1:0] push_addr_i,
  input  logic                          push_err_i,
  // Consumer side
  output logic                          fetch_valid_o,
  input  logic                          fetch_ready_i,
  output logic [ifetch_pkg::DATA_W-1:0] fetch_rdata_o,
  output logic [ifetch_pkg::ADDR_W-1:0] fetch_addr_o,
  output logic                          fetch_err_o,
  output logic                          credit_ret_o
);
  import ifetch_pkg::*;

  localparam int unsigned CntW = $clog2(BufDepth + 1);
  localparam int unsigned PtrW = $clog2(BufDepth);

  logic [DATA_W-1:0]   rdata_mem [BufDepth];
  logic [ADDR_W-1:0]   addr_mem  [BufDepth];
  logic [BufDepth-1:0] err_mem;
  logic [PtrW-1:0]     wr_ptr_q;
  logic [PtrW-1:0]     rd_ptr_q;
  logic [CntW-1:0]     count_q;
  logic                push;
  logic                pop;

  // Branch acts as flush
  assign push = push_valid_i && !branch_i;
  assign pop  = fetch_valid_o && fetch_ready_i;

  // Head entry
  assign fetch_valid_o = (count_q != '0);
  assign fetch_rdata_o = rdata_mem[rd_ptr_q];
  assign fetch_addr_o  = addr_mem[rd_ptr_q];
  assign fetch_err_o   = err_mem[rd_ptr_q];

  // Controller recomputes its credits on flush
  assign credit_ret_o = pop && !branch_i;

  always_ff @(posedge clk_i) begin
    if (reset_i || branch_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(push) - CntW'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      rdata_mem[wr_ptr_q] <= push_rdata_i;
      addr_mem[wr_ptr_q]  <= push_addr_i;
      err_mem[wr_ptr_q]   <= push_err_i;
    end
  end

endmodule

// ==== hw/ifetch_top.sv ====
// ==================================================
// Instruction fetch stage top. Bus on one side, a
// valid/ready word stream to the core on the other
// ==================================================
`timescale 1ns/1ps

module ifetch_top #(
  parameter int unsigned BufDepth = ifetch_pkg::BUF_DEPTH_DEFAULT
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          fetch_enable_i,
  input  logic                          branch_i,
  input  logic [ifetch_pkg::ADDR_W-1:0] branch_addr_i,
  // Instruction bus
  output logic                          instr_req_o,
  input  logic                          instr_gnt_i,
  output logic [ifetch_pkg::ADDR_W-1:0] instr_addr_o,
  input  logic                          instr_rvalid_i,
  input  logic [ifetch_pkg::DATA_W-1:0] instr_rdata_i,
  input  logic                          instr_err_i,
  // Core side
  output logic                          fetch_valid_o,
  input  logic                          fetch_ready_i,
  output logic [ifetch_pkg::DATA_W-1:0] fetch_rdata_o,
  output logic [ifetch_pkg::ADDR_W-1:0] fetch_addr_o,
  output logic                          fetch_err_o
);
  import ifetch_pkg::*;

  logic              push_valid;
  logic [DATA_W-1:0] push_rdata;
  logic [ADDR_W-1:0] push_addr;
  logic              push_err;
  logic              credit_ret;

  ifetch_req_ctrl #(
    .BufDepth (BufDepth)
  ) u_req_ctrl (
    .clk_i          (clk_i         ),
    .reset_i        (reset_i       ),
    .fetch_enable_i (fetch_enable_i),
    .branch_i       (branch_i      ),
    .branch_addr_i  (branch_addr_i ),
    .instr_req_o    (instr_req_o   ),
    .instr_gnt_i    (instr_gnt_i   ),
    .instr_addr_o   (instr_addr_o  ),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i ),
    .instr_err_i    (instr_err_i   ),
    .credit_ret_i   (credit_ret    ),
    .push_valid_o   (push_valid    ),
    .push_rdata_o   (push_rdata    ),
    .push_addr_o    (push_addr     ),
    .push_err_o     (push_err      )
  );

  ifetch_prefetch_buf #(
    .BufDepth (BufDepth)
  ) u_prefetch_buf (
    .clk_i         (clk_i        ),
    .reset_i       (reset_i      ),
    .branch_i      (branch_i     ),
    .push_valid_i  (push_valid   ),
    .push_rdata_i  (push_rdata   ),
    .push_addr_i   (push_addr    ),
    .push_err_i    (push_err     ),
    .fetch_valid_o (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i),
    .fetch_rdata_o (fetch_rdata_o),
    .fetch_addr_o  (fetch_addr_o ),
    .fetch_err_o   (fetch_err_o  ),
    .credit_ret_o  (credit_ret   )
  );

endmodule

// ==== testbench/ifetch_bus_chk.sv ====
// ==================================================
// Bus protocol and credit checks for the fetch stage.
// Bound to ifetch_top from the testbench top
// ==================================================
`timescale 1ns/1ps

module ifetch_bus_chk #(
  parameter int unsigned BufDepth = ifetch_pkg::BUF_DEPTH_DEFAULT
) (
  input logic                          clk_i,
  input logic                          reset_i,
  input logic                          branch_i,
  input logic                          instr_req_o,
  input logic                          instr_gnt_i,
  input logic [ifetch_pkg::ADDR_W-1:0] instr_addr_o,
  input logic                          instr_rvalid_i
);
  import ifetch_pkg::*;

  int unsigned fail_count = 0;
  int unsigned outstanding_q;

  // Granted requests still waiting for rvalid
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_q <= 0;
    end else begin
      outstanding_q <= outstanding_q + int'(instr_req_o && instr_gnt_i) - int'(instr_rvalid_i);
    end
  end

  credit_limit: assert property (@(posedge clk_i) disable iff (reset_i)
    outstanding_q <= BufDepth)
    else begin
      $error("outstanding requests exceed the buffer depth");
      fail_count++;
    end

  // Branch drops a waiting request in its own cycle
  addr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    instr_req_o && !instr_gnt_i |=> branch_i || (instr_req_o && $stable(instr_addr_o)))
    else begin
      $error("request dropped or address changed before grant");
      fail_count++;
    end

  word_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    instr_req_o |-> instr_addr_o[ADDR_LSB-1:0] == '0)
    else begin
      $error("request address not word aligned");
      fail_count++;
    end

endmodule

// ==== testbench/ifetch_tb_top.sv ====
// ==================================================
// Testbench for the fetch stage. Random bus responder,
// random consumer and branches, checked against a model
// ==================================================
`timescale 1ns/1ps

module ifetch_tb_top;
  import ifetch_pkg::*;

  localparam int unsigned       BufDepth     = BUF_DEPTH_DEFAULT;
  localparam int                RunCycles    = 3000;
  localparam int                EnableCycle  = 20;
  localparam int                StallLimit   = 200;
  localparam int                DrainWords   = 16;
  localparam int                DrainTimeout = 400;
  localparam logic [DATA_W-1:0] DataMask     = 32'hA5A5_0F0F;

  logic              clk = 1'b0;
  logic              reset_i;
  logic              fetch_enable_i;
  logic              branch_i;
  logic [ADDR_W-1:0] branch_addr_i;
  logic              instr_req_o;
  logic              instr_gnt_i;
  logic [ADDR_W-1:0] instr_addr_o;
  logic              instr_rvalid_i;
  logic [DATA_W-1:0] instr_rdata_i;
  logic              instr_err_i;
  logic              fetch_valid_o;
  logic              fetch_ready_i;
  logic [DATA_W-1:0] fetch_rdata_o;
  logic [ADDR_W-1:0] fetch_addr_o;
  logic              fetch_err_o;

  integer            seed;
  int                cyc;
  int                consumed;
  int                idle_cycles;
  logic [ADDR_W-1:0] exp_addr;
  // Responder queue of granted addresses and their rvalid due cycles
  logic [ADDR_W-1:0] pend_addr [$];
  int                pend_due [$];
  logic              hold_valid;
  logic [DATA_W-1:0] hold_rdata;
  logic [ADDR_W-1:0] hold_addr;
  logic              hold_err;
  logic              branch_prev;

  always #2 clk = ~clk;

  ifetch_top #(
    .BufDepth (BufDepth)
  ) dut_i (
    .clk_i          (clk           ),
    .reset_i        (reset_i       ),
    .fetch_enable_i (fetch_enable_i),
    .branch_i       (branch_i      ),
    .branch_addr_i  (branch_addr_i ),
    .instr_req_o    (instr_req_o   ),
    .instr_gnt_i    (instr_gnt_i   ),
    .instr_addr_o   (instr_addr_o  ),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i ),
    .instr_err_i    (instr_err_i   ),
    .fetch_valid_o  (fetch_valid_o ),
    .fetch_ready_i  (fetch_ready_i ),
    .fetch_rdata_o  (fetch_rdata_o ),
    .fetch_addr_o   (fetch_addr_o  ),
    .fetch_err_o    (fetch_err_o   )
  );

  bind ifetch_top ifetch_bus_chk #(
    .BufDepth (BufDepth)
  ) u_bus_chk (
    .clk_i          (clk_i         ),
    .reset_i        (reset_i       ),
    .branch_i       (branch_i      ),
    .instr_req_o    (instr_req_o   ),
    .instr_gnt_i    (instr_gnt_i   ),
    .instr_addr_o   (instr_addr_o  ),
    .instr_rvalid_i (instr_rvalid_i)
  );

  function automatic logic [DATA_W-1:0] word_data(input logic [ADDR_W-1:0] addr);
    return addr ^ DataMask;
  endfunction

  // Error region is any address with bits 11:8 all set
  function automatic logic word_err(input logic [ADDR_W-1:0] addr);
    return addr[11:8] == 4'hF;
  endfunction

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
    abort_run();
  endtask

  task automatic report_failure(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic drive_inputs(input bit quiet);
    fetch_enable_i = (cyc >= EnableCycle);
    instr_gnt_i    = (($random(seed) & 3) != 0);
    if (pend_addr.size() != 0 && pend_due[0] <= cyc) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = word_data(pend_addr[0]);
      instr_err_i    = word_err(pend_addr[0]);
    end else begin
      instr_rvalid_i = 1'b0;
      instr_rdata_i  = $random(seed);
      instr_err_i    = 1'b0;
    end
    fetch_ready_i = quiet || (($random(seed) & 3) != 0);
    branch_i      = !quiet && fetch_enable_i && ({$random(seed)} % 40 == 0);
    if (branch_i) begin
      branch_addr_i = $random(seed);
    end
  endtask

  task automatic observe_outputs();
    if (hold_valid) begin
      assert (fetch_valid_o) else report_failure("fetch_valid_o dropped while stalled");
      assert (fetch_rdata_o == hold_rdata)
        else report_mismatch("fetch_rdata_o", fetch_rdata_o, hold_rdata);
      assert (fetch_addr_o == hold_addr)
        else report_mismatch("fetch_addr_o", fetch_addr_o, hold_addr);
      assert (fetch_err_o == hold_err)
        else report_mismatch("fetch_err_o", 32'(fetch_err_o), 32'(hold_err));
    end
    if (branch_prev) begin
      assert (!fetch_valid_o) else report_failure("fetch_valid_o high right after a branch");
    end
    if (!fetch_enable_i) begin
      assert (!instr_req_o) else report_failure("bus request before fetch was enabled");
      assert (!fetch_valid_o) else report_failure("fetch_valid_o before fetch was enabled");
    end
    // Consumed word against the model stream
    if (fetch_valid_o && fetch_ready_i) begin
      assert (fetch_addr_o == exp_addr)
        else report_mismatch("fetch_addr_o", fetch_addr_o, exp_addr);
      assert (fetch_rdata_o == word_data(exp_addr))
        else report_mismatch("fetch_rdata_o", fetch_rdata_o, word_data(exp_addr));
      assert (fetch_err_o == word_err(exp_addr))
        else report_mismatch("fetch_err_o", 32'(fetch_err_o), 32'(word_err(exp_addr)));
      exp_addr    = exp_addr + 32'd4;
      consumed    = consumed + 1;
      idle_cycles = 0;
    end else if (fetch_enable_i) begin
      idle_cycles = idle_cycles + 1;
    end
    if (branch_i) begin
      exp_addr = branch_addr_i & ~32'h3;
    end
    if (instr_req_o && instr_gnt_i) begin
      pend_addr.push_back(instr_addr_o);
      pend_due.push_back(cyc + 1 + ({$random(seed)} % 4));
    end
    if (instr_rvalid_i) begin
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end
    hold_valid  = fetch_valid_o && !fetch_ready_i && !branch_i;
    hold_rdata  = fetch_rdata_o;
    hold_addr   = fetch_addr_o;
    hold_err    = fetch_err_o;
    branch_prev = branch_i;
    assert (dut_i.u_bus_chk.fail_count == 0) else report_failure("bus protocol assertion fired");
    assert (idle_cycles <= StallLimit) else report_failure("no word consumed for too long");
  endtask

  initial begin
    int target;
    int wait_cycles;
    seed           = 32'h23056b33;
    reset_i        = 1'b1;
    fetch_enable_i = 1'b0;
    branch_i       = 1'b0;
    branch_addr_i  = '0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    fetch_ready_i  = 1'b0;
    consumed       = 0;
    idle_cycles    = 0;
    exp_addr       = '0;
    hold_valid     = 1'b0;
    branch_prev    = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;

    for (cyc = 0; cyc < RunCycles; cyc++) begin
      @(negedge clk);
      drive_inputs(1'b0);
      @(posedge clk);
      observe_outputs();
    end

    // Drain with the consumer always ready
    target      = consumed + DrainWords;
    wait_cycles = 0;
    while (consumed < target) begin
      assert (wait_cycles < DrainTimeout)
        else report_failure("timeout waiting for words at the end of the run");
      @(negedge clk);
      drive_inputs(1'b1);
      @(posedge clk);
      observe_outputs();
      cyc         = cyc + 1;
      wait_cycles = wait_cycles + 1;
    end

    if (dut_i.u_bus_chk.fail_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      report_failure("bus protocol assertion fired");
    end
  end

endmodule

// ==== verilog.f ====
hw/ifetch_pkg.sv
hw/ifetch_req_ctrl.sv
hw/ifetch_prefetch_buf.sv
hw/ifetch_top.sv
testbench/ifetch_bus_chk.sv
testbench/ifetch_tb_top.sv

// ==== Makefile ====
# Verilator build and run for the instruction fetch stage

VERILATOR ?= verilator
TOP       ?= ifetch_tb_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qF '>>> FAIL' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -qF '>>> PASS' $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
